// ==== mips_isa_pkg.sv ====
package mips_isa_pkg;

    typedef logic [4:0] reg_index_t;

    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a
    } funct_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_index_t rs;
        reg_index_t rt;
        reg_index_t rd;
        logic [4:0] shamt;
        funct_t     funct;
    } r_format_t;

    typedef struct packed {
        opcode_t     opcode;
        reg_index_t  rs;
        reg_index_t  rt;
        logic [15:0] imm;
    } i_format_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] target; // word index inside the current 256 MB region
    } j_format_t;

    // the opcode sits in the same bits in all three views
    typedef union packed {
        r_format_t r;
        i_format_t i;
        j_format_t j;
    } instruction_t;

endpackage

// ==== pipeline_pkg.sv ====
package pipeline_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll
    } alu_op_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;   // second ALU operand comes from the immediate
        logic    write_reg;
        logic    mem_read;
        logic    mem_write;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
    } control_t;

    typedef struct packed {
        logic                       valid;
        mips_isa_pkg::instruction_t instruction;
        logic [31:0]                pc;
        logic [31:0]                pc_add4;
    } decode_state_t;

    typedef struct packed {
        logic                     valid;
        control_t                 control;
        mips_isa_pkg::reg_index_t rs;
        mips_isa_pkg::reg_index_t rt;
        mips_isa_pkg::reg_index_t dest_reg;
        logic [31:0]              operand_a;
        logic [31:0]              operand_b;
        logic [31:0]              store_data;
        logic [31:0]              immediate;   // sign extended, also carries shamt for sll
        logic [31:0]              pc_add4;
        logic [31:0]              jump_target;
    } execute_state_t;

    typedef struct packed {
        logic                     valid;
        control_t                 control;
        mips_isa_pkg::reg_index_t dest_reg;
        logic [31:0]              alu_result;
        logic [31:0]              store_data;
    } memory_state_t;

    typedef struct packed {
        logic                     valid;
        logic                     write_reg;
        mips_isa_pkg::reg_index_t dest_reg;
        logic [31:0]              dest_reg_data;
    } write_back_state_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_memory,
        fwd_write_back
    } forward_sel_t;

    typedef struct packed {
        forward_sel_t rs;
        forward_sel_t rt;
    } forward_info_t;

    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } data_req_t;

endpackage

// ==== stage_fetch.sv ====
`timescale 1ns/100ps

module stage_fetch #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          load,
    input  logic [31:0]                   pc_in,
    input  logic                          nullify,
    output logic [31:0]                   iaddr,
    input  mips_isa_pkg::instruction_t    idata,
    output pipeline_pkg::decode_state_t   decode_state
);

    logic [31:0] pc;
    logic [31:0] pc_add4;

    assign pc_add4 = pc + 32'd4;
    assign iaddr = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
        end else if (load) begin
            pc <= pc_in; // redirect from execute wins over sequential fetch
        end else begin
            pc <= pc_add4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            decode_state <= '0;
        end else begin
            decode_state.valid <= !nullify;
            decode_state.instruction <= idata;
            decode_state.pc <= pc;
            decode_state.pc_add4 <= pc_add4;
        end
    end

endmodule

// ==== stage_decode.sv ====
`timescale 1ns/100ps

module stage_decode (
    input  logic                              clk,
    input  logic                              arst_n,
    input  pipeline_pkg::decode_state_t       decode_state,
    input  pipeline_pkg::write_back_state_t   write_back,
    input  logic                              nullify,
    output pipeline_pkg::execute_state_t      execute_state
);

    mips_isa_pkg::instruction_t ins;
    mips_isa_pkg::reg_index_t   dest_reg;
    pipeline_pkg::control_t     ctrl;
    logic [31:0]                regs [1:31];
    logic [31:0]                imm_sext;
    logic [31:0]                imm_alu;
    logic [31:0]                rs_value;
    logic [31:0]                rt_value;
    logic                       wb_write;

    assign ins = decode_state.instruction;
    assign imm_sext = {{16{ins.i.imm[15]}}, ins.i.imm};
    assign wb_write = write_back.valid && write_back.write_reg && (write_back.dest_reg != '0);

    // a register written this cycle is seen by the instruction being decoded
    function automatic logic [31:0] read_operand(input mips_isa_pkg::reg_index_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_write && (write_back.dest_reg == idx)) begin
            return write_back.dest_reg_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs_value = read_operand(ins.r.rs);
        rt_value = read_operand(ins.r.rt);
    end

    always_comb begin
        ctrl = '0;
        dest_reg = ins.i.rt;
        imm_alu = imm_sext;
        case (ins.r.opcode)
            mips_isa_pkg::op_special: begin
                dest_reg = ins.r.rd;
                ctrl.write_reg = 1'b1;
                case (ins.r.funct)
                    mips_isa_pkg::fn_addu: ctrl.alu_op = pipeline_pkg::alu_add;
                    mips_isa_pkg::fn_subu: ctrl.alu_op = pipeline_pkg::alu_sub;
                    mips_isa_pkg::fn_and: ctrl.alu_op = pipeline_pkg::alu_and;
                    mips_isa_pkg::fn_or: ctrl.alu_op = pipeline_pkg::alu_or;
                    mips_isa_pkg::fn_xor: ctrl.alu_op = pipeline_pkg::alu_xor;
                    mips_isa_pkg::fn_slt: ctrl.alu_op = pipeline_pkg::alu_slt;
                    mips_isa_pkg::fn_sll: ctrl.alu_op = pipeline_pkg::alu_sll;
                    default: ctrl.write_reg = 1'b0; // unknown funct behaves as a nop
                endcase
            end
            mips_isa_pkg::op_addiu, mips_isa_pkg::op_lw: begin
                ctrl.alu_op = pipeline_pkg::alu_add;
                ctrl.use_imm = 1'b1;
                ctrl.write_reg = 1'b1;
                ctrl.mem_read = (ins.i.opcode == mips_isa_pkg::op_lw);
            end
            mips_isa_pkg::op_andi: begin
                ctrl.alu_op = pipeline_pkg::alu_and;
                ctrl.use_imm = 1'b1;
                ctrl.write_reg = 1'b1;
                imm_alu = {16'h0, ins.i.imm};
            end
            mips_isa_pkg::op_ori, mips_isa_pkg::op_lui: begin
                ctrl.alu_op = pipeline_pkg::alu_or; // lui has rs = 0, so or with zero
                ctrl.use_imm = 1'b1;
                ctrl.write_reg = 1'b1;
                if (ins.i.opcode == mips_isa_pkg::op_lui) begin
                    imm_alu = {ins.i.imm, 16'h0};
                end else begin
                    imm_alu = {16'h0, ins.i.imm};
                end
            end
            mips_isa_pkg::op_sw: begin
                ctrl.alu_op = pipeline_pkg::alu_add;
                ctrl.use_imm = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            mips_isa_pkg::op_beq: ctrl.branch_eq = 1'b1;
            mips_isa_pkg::op_bne: ctrl.branch_ne = 1'b1;
            mips_isa_pkg::op_j: ctrl.jump = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wb_write) begin
            regs[write_back.dest_reg] <= write_back.dest_reg_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            execute_state <= '0;
        end else if (nullify) begin
            execute_state <= '0;
        end else begin
            execute_state.valid <= decode_state.valid;
            execute_state.control <= ctrl;
            execute_state.rs <= ins.r.rs;
            execute_state.rt <= ins.r.rt;
            execute_state.dest_reg <= dest_reg;
            execute_state.operand_a <= rs_value;
            execute_state.operand_b <= ctrl.use_imm ? imm_alu : rt_value;
            execute_state.store_data <= rt_value;
            execute_state.immediate <= imm_sext;
            execute_state.pc_add4 <= decode_state.pc_add4;
            execute_state.jump_target <= {decode_state.pc_add4[31:28], ins.j.target, 2'b00};
        end
    end

endmodule

// ==== stage_execute.sv ====
`timescale 1ns/100ps

module stage_execute (
    input  logic                             clk,
    input  logic                             arst_n,
    input  pipeline_pkg::execute_state_t     execute_state,
    input  pipeline_pkg::forward_info_t      forward,
    input  logic [31:0]                      memory_result,
    input  logic [31:0]                      write_back_result,
    output pipeline_pkg::memory_state_t      memory_state,
    output logic                             redirect,
    output logic [31:0]                      redirect_pc
);

    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rt_value;
    logic [31:0] result;
    logic        taken;

    function automatic logic [31:0] pick(input pipeline_pkg::forward_sel_t sel,
                                         input logic [31:0] value);
        case (sel)
            pipeline_pkg::fwd_memory: return memory_result;
            pipeline_pkg::fwd_write_back: return write_back_result;
            default: return value;
        endcase
    endfunction

    always_comb begin
        a = pick(forward.rs, execute_state.operand_a);
        rt_value = pick(forward.rt, execute_state.store_data);
        b = execute_state.control.use_imm ? execute_state.operand_b
                                          : pick(forward.rt, execute_state.operand_b);
    end

    always_comb begin
        case (execute_state.control.alu_op)
            pipeline_pkg::alu_sub: result = a - b;
            pipeline_pkg::alu_and: result = a & b;
            pipeline_pkg::alu_or: result = a | b;
            pipeline_pkg::alu_xor: result = a ^ b;
            pipeline_pkg::alu_slt: result = {31'b0, $signed(a) < $signed(b)};
            pipeline_pkg::alu_sll: result = b << execute_state.immediate[10:6]; // shamt field
            default: result = a + b;
        endcase
    end

    assign taken = (execute_state.control.branch_eq && (a == rt_value))
                || (execute_state.control.branch_ne && (a != rt_value))
                || execute_state.control.jump;
    assign redirect = execute_state.valid && taken;
    assign redirect_pc = execute_state.control.jump ? execute_state.jump_target
                       : execute_state.pc_add4 + {execute_state.immediate[29:0], 2'b00};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            memory_state <= '0;
        end else begin
            memory_state.valid <= execute_state.valid;
            memory_state.control <= execute_state.control;
            memory_state.dest_reg <= execute_state.dest_reg;
            memory_state.alu_result <= result;
            memory_state.store_data <= rt_value;
        end
    end

endmodule

// ==== stage_memory.sv ====
`timescale 1ns/100ps

module stage_memory (
    input  logic                              clk,
    input  logic                              arst_n,
    input  pipeline_pkg::memory_state_t       memory_state,
    output pipeline_pkg::data_req_t           data_req,
    input  logic [31:0]                       rdata,
    output pipeline_pkg::write_back_state_t   write_back
);

    assign data_req.read = memory_state.valid && memory_state.control.mem_read;
    assign data_req.write = memory_state.valid && memory_state.control.mem_write;
    assign data_req.addr = memory_state.alu_result;
    assign data_req.wdata = memory_state.store_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            write_back <= '0;
        end else begin
            write_back.valid <= memory_state.valid;
            write_back.write_reg <= memory_state.control.write_reg;
            write_back.dest_reg <= memory_state.dest_reg;
            // rdata answers in the same cycle as the request
            write_back.dest_reg_data <= memory_state.control.mem_read ? rdata
                                                                      : memory_state.alu_result;
        end
    end

endmodule

// ==== main_forwarder.sv ====
`timescale 1ns/100ps

module main_forwarder (
    input  pipeline_pkg::execute_state_t      execute_state,
    input  pipeline_pkg::memory_state_t       memory_state,
    input  pipeline_pkg::write_back_state_t   write_back,
    output pipeline_pkg::forward_info_t       forward
);

    // the younger producer in memory shadows an older one in write back
    function automatic pipeline_pkg::forward_sel_t select_source(
        input mips_isa_pkg::reg_index_t src
    );
        if (src == '0) begin
            return pipeline_pkg::fwd_none;
        end
        if (memory_state.valid && memory_state.control.write_reg
                && (memory_state.dest_reg == src)) begin
            return pipeline_pkg::fwd_memory;
        end
        if (write_back.valid && write_back.write_reg && (write_back.dest_reg == src)) begin
            return pipeline_pkg::fwd_write_back;
        end
        return pipeline_pkg::fwd_none;
    endfunction

    always_comb begin
        forward.rs = select_source(execute_state.rs);
        forward.rt = select_source(execute_state.rt);
    end

endmodule

// ==== pipeline_flow_controller.sv ====
`timescale 1ns/100ps

module pipeline_flow_controller (
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    output logic        load,
    output logic [31:0] pc,
    output logic        nullify_decode,
    output logic        nullify_execute
);

    // no delay slot, so both instructions behind a taken branch are dropped
    always_comb begin
        load = redirect;
        pc = redirect_pc;
        nullify_decode = redirect;  // instruction being fetched now
        nullify_execute = redirect; // instruction sitting in decode
    end

endmodule

// ==== core.sv ====
`timescale 1ns/100ps

module core #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  logic                          clk,
    input  logic                          arst_n,
    output logic [31:0]                   iaddr,
    input  mips_isa_pkg::instruction_t    idata,
    output pipeline_pkg::data_req_t       data_req,
    input  logic [31:0]                   rdata
);

    pipeline_pkg::decode_state_t     decode_state;
    pipeline_pkg::execute_state_t    execute_state;
    pipeline_pkg::memory_state_t     memory_state;
    pipeline_pkg::write_back_state_t write_back;
    pipeline_pkg::forward_info_t     execute_forward;

    logic        redirect;
    logic [31:0] redirect_pc;
    logic        load_pc;
    logic [31:0] pc_value;
    logic        nullify_decode;
    logic        nullify_execute;

    stage_fetch #(.reset_pc(reset_pc)) unit_fetch (
        .clk(clk), .arst_n(arst_n),
        .load(load_pc), .pc_in(pc_value), .nullify(nullify_decode),
        .iaddr(iaddr), .idata(idata),
        .decode_state(decode_state)
    );

    stage_decode unit_decode (
        .clk(clk), .arst_n(arst_n),
        .decode_state(decode_state), .write_back(write_back),
        .nullify(nullify_execute), .execute_state(execute_state)
    );

    main_forwarder unit_forwarder (
        .execute_state(execute_state), .memory_state(memory_state),
        .write_back(write_back), .forward(execute_forward)
    );

    stage_execute unit_execute (
        .clk(clk), .arst_n(arst_n),
        .execute_state(execute_state), .forward(execute_forward),
        .memory_result(memory_state.alu_result),
        .write_back_result(write_back.dest_reg_data),
        .memory_state(memory_state),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

    stage_memory unit_memory (
        .clk(clk), .arst_n(arst_n),
        .memory_state(memory_state), .data_req(data_req), .rdata(rdata),
        .write_back(write_back)
    );

    pipeline_flow_controller unit_flow_controller (
        .redirect(redirect), .redirect_pc(redirect_pc),
        .load(load_pc), .pc(pc_value),
        .nullify_decode(nullify_decode), .nullify_execute(nullify_execute)
    );

endmodule

// ==== core_assert.sv ====
`timescale 1ns/100ps

module core_assert #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input logic                    clk,
    input logic                    arst_n,
    input logic [31:0]             iaddr,
    input pipeline_pkg::data_req_t data_req,
    input logic                    redirect,
    input logic [31:0]             redirect_pc
);

    int unsigned failures = 0;

    reset_quiet: assert property (@(posedge clk)
            !arst_n |-> (iaddr == reset_pc) && !data_req.read && !data_req.write)
        else begin
            failures++;
            $error("fetch address left reset_pc or a data request was active during reset");
        end

    // sequential fetch whenever execute resolves nothing
    fetch_step: assert property (@(posedge clk) disable iff (!arst_n)
            !redirect |=> iaddr == $past(iaddr) + 32'd4)
        else begin
            failures++;
            $error("iaddr did not advance by 4 without a redirect");
        end

    fetch_redirect: assert property (@(posedge clk) disable iff (!arst_n)
            redirect |=> iaddr == $past(redirect_pc))
        else begin
            failures++;
            $error("iaddr did not load the redirect target");
        end

    store_clean: assert property (@(posedge clk) disable iff (!arst_n)
            data_req.write |-> !data_req.read && (data_req.addr[1:0] == 2'b00)
                               && !$isunknown(data_req.wdata))
        else begin
            failures++;
            $error("data write is misaligned, overlaps a read or carries unknown data");
        end

endmodule

bind core core_assert #(.reset_pc(reset_pc)) checks0 (
    .clk(clk), .arst_n(arst_n), .iaddr(iaddr), .data_req(data_req),
    .redirect(redirect), .redirect_pc(redirect_pc)
);

// ==== core_tb.sv ====
`timescale 1ns/100ps

module core_tb;

    localparam logic [31:0] start_pc = 32'h0;

    logic                       clk;
    logic                       arst_n;
    logic [31:0]                iaddr;
    mips_isa_pkg::instruction_t idata;
    pipeline_pkg::data_req_t    data_req;
    logic [31:0]                rdata;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] expected_addr [$];
    logic [31:0] expected_data [$];
    logic [31:0] want_addr;
    logic [31:0] want_data;
    logic [31:0] halt_pc;
    logic        program_ready;
    int          prog_len;
    int          seed;
    int          errors;

    core #(.reset_pc(start_pc)) dut0 (
        .clk(clk), .arst_n(arst_n), .iaddr(iaddr), .idata(idata),
        .data_req(data_req), .rdata(rdata)
    );

    assign idata = imem[iaddr[9:2]];
    assign rdata = data_req.read ? dmem[data_req.addr[9:2]] : 32'bx; // data only while read is up

    // arguments follow assembly order rd, rs, rt
    function automatic logic [31:0] rtype_word(mips_isa_pkg::funct_t fn, int rd, int rs, int rt,
                                               int shamt);
        mips_isa_pkg::instruction_t w;
        w.r.opcode = mips_isa_pkg::op_special;
        w.r.rs = 5'(rs);
        w.r.rt = 5'(rt);
        w.r.rd = 5'(rd);
        w.r.shamt = 5'(shamt);
        w.r.funct = fn;
        return w;
    endfunction

    function automatic logic [31:0] itype_word(mips_isa_pkg::opcode_t op, int rt, int rs,
                                               logic [15:0] imm);
        mips_isa_pkg::instruction_t w;
        w.i.opcode = op;
        w.i.rs = 5'(rs);
        w.i.rt = 5'(rt);
        w.i.imm = imm;
        return w;
    endfunction

    function automatic logic [31:0] jtype_word(logic [31:0] target_pc);
        mips_isa_pkg::instruction_t w;
        w.j.opcode = mips_isa_pkg::op_j;
        w.j.target = target_pc[27:2];
        return w;
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic build_program();
        logic [31:0] value;
        for (int r = 1; r <= 6; r++) begin
            value = $random(seed) | 32'h1; // odd values keep every seeded register nonzero
            emit(itype_word(mips_isa_pkg::op_lui, r, 0, value[31:16]));
            emit(itype_word(mips_isa_pkg::op_ori, r, r, value[15:0]));
        end
        emit(rtype_word(mips_isa_pkg::fn_addu, 7, 1, 2, 0));
        emit(rtype_word(mips_isa_pkg::fn_subu, 8, 7, 3, 0));
        emit(rtype_word(mips_isa_pkg::fn_xor, 9, 8, 7, 0));
        emit(itype_word(mips_isa_pkg::op_sw, 9, 0, 16'h0200));
        emit(rtype_word(mips_isa_pkg::fn_and, 10, 9, 4, 0));
        emit(32'h0);
        emit(rtype_word(mips_isa_pkg::fn_or, 11, 10, 5, 0)); // one gap behind its producer
        emit(rtype_word(mips_isa_pkg::fn_sll, 12, 0, 11, 5));
        emit(32'h0);
        emit(32'h0);
        emit(rtype_word(mips_isa_pkg::fn_slt, 13, 12, 1, 0));
        emit(itype_word(mips_isa_pkg::op_sw, 10, 0, 16'h0204));
        emit(itype_word(mips_isa_pkg::op_sw, 11, 0, 16'h0208));
        emit(itype_word(mips_isa_pkg::op_sw, 12, 0, 16'h020c));
        emit(itype_word(mips_isa_pkg::op_sw, 13, 0, 16'h0210));
        emit(itype_word(mips_isa_pkg::op_addiu, 14, 13, 16'hfffb));
        emit(itype_word(mips_isa_pkg::op_andi, 15, 6, 16'hf0f0));
        emit(itype_word(mips_isa_pkg::op_sw, 14, 0, 16'h0214));
        emit(itype_word(mips_isa_pkg::op_sw, 15, 0, 16'h0218));
        emit(itype_word(mips_isa_pkg::op_lw, 17, 0, 16'h0040));
        emit(itype_word(mips_isa_pkg::op_addiu, 16, 2, 16'h0123));
        emit(rtype_word(mips_isa_pkg::fn_addu, 18, 17, 1, 0));
        emit(itype_word(mips_isa_pkg::op_sw, 18, 0, 16'h0220));
        emit(itype_word(mips_isa_pkg::op_sw, 17, 0, 16'h0224));
        emit(itype_word(mips_isa_pkg::op_sw, 16, 0, 16'h0228));
        emit(itype_word(mips_isa_pkg::op_beq, 1, 1, 16'h0002));
        emit(itype_word(mips_isa_pkg::op_sw, 1, 0, 16'h0230));
        emit(itype_word(mips_isa_pkg::op_sw, 2, 0, 16'h0234));
        emit(itype_word(mips_isa_pkg::op_sw, 3, 0, 16'h0238));
        emit(itype_word(mips_isa_pkg::op_bne, 0, 1, 16'h0002));
        emit(itype_word(mips_isa_pkg::op_sw, 4, 0, 16'h023c));
        emit(itype_word(mips_isa_pkg::op_sw, 5, 0, 16'h0240));
        emit(itype_word(mips_isa_pkg::op_sw, 6, 0, 16'h0244));
        emit(jtype_word((prog_len + 3) * 4));
        emit(itype_word(mips_isa_pkg::op_sw, 7, 0, 16'h0248));
        emit(itype_word(mips_isa_pkg::op_sw, 8, 0, 16'h024c));
        emit(itype_word(mips_isa_pkg::op_sw, 9, 0, 16'h0250));
        emit(itype_word(mips_isa_pkg::op_beq, 0, 1, 16'h0002)); // r1 is odd so this falls through
        emit(itype_word(mips_isa_pkg::op_sw, 10, 0, 16'h0254));
        emit(itype_word(mips_isa_pkg::op_bne, 2, 2, 16'h0002));
        emit(itype_word(mips_isa_pkg::op_sw, 11, 0, 16'h0258));
        emit(itype_word(mips_isa_pkg::op_sw, 12, 0, 16'h025c));
        emit(itype_word(mips_isa_pkg::op_addiu, 0, 1, 16'h0007));
        emit(itype_word(mips_isa_pkg::op_sw, 0, 0, 16'h0260));
        emit(itype_word(mips_isa_pkg::op_ori, 0, 0, 16'h0055));
        emit(32'h0);
        emit(itype_word(mips_isa_pkg::op_sw, 0, 0, 16'h0264));
        emit(rtype_word(mips_isa_pkg::fn_addu, 0, 1, 2, 0));
        emit(32'h0);
        emit(32'h0);
        emit(32'h0);
        emit(itype_word(mips_isa_pkg::op_sw, 0, 0, 16'h0268));
        halt_pc = prog_len * 4;
        emit(jtype_word(halt_pc)); // jump to itself ends the program
    endtask

    // architectural model that runs one instruction per step with no delay slot
    task automatic run_model();
        logic [31:0]                regs [0:31];
        logic [31:0]                mem [0:255];
        logic [31:0]                pc;
        logic [31:0]                next_pc;
        logic [31:0]                simm;
        logic [31:0]                zimm;
        logic [31:0]                addr;
        logic [31:0]                a;
        logic [31:0]                b;
        mips_isa_pkg::instruction_t ins;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = dmem[i];
        end
        pc = start_pc;
        for (int step = 0; step < 4 * prog_len && pc != halt_pc; step++) begin
            ins = imem[pc[9:2]];
            a = regs[ins.r.rs];
            b = regs[ins.r.rt];
            simm = {{16{ins.i.imm[15]}}, ins.i.imm};
            zimm = {16'h0, ins.i.imm};
            addr = a + simm;
            next_pc = pc + 32'd4;
            case (ins.r.opcode)
                mips_isa_pkg::op_special: begin
                    case (ins.r.funct)
                        mips_isa_pkg::fn_addu: regs[ins.r.rd] = a + b;
                        mips_isa_pkg::fn_subu: regs[ins.r.rd] = a - b;
                        mips_isa_pkg::fn_and: regs[ins.r.rd] = a & b;
                        mips_isa_pkg::fn_or: regs[ins.r.rd] = a | b;
                        mips_isa_pkg::fn_xor: regs[ins.r.rd] = a ^ b;
                        mips_isa_pkg::fn_slt: regs[ins.r.rd] = ($signed(a) < $signed(b)) ? 1 : 0;
                        mips_isa_pkg::fn_sll: regs[ins.r.rd] = b << ins.r.shamt;
                        default: ;
                    endcase
                end
                mips_isa_pkg::op_addiu: regs[ins.i.rt] = a + simm;
                mips_isa_pkg::op_andi: regs[ins.i.rt] = a & zimm;
                mips_isa_pkg::op_ori: regs[ins.i.rt] = a | zimm;
                mips_isa_pkg::op_lui: regs[ins.i.rt] = {ins.i.imm, 16'h0};
                mips_isa_pkg::op_lw: regs[ins.i.rt] = mem[addr[9:2]];
                mips_isa_pkg::op_sw: begin
                    mem[addr[9:2]] = b;
                    expected_addr.push_back(addr);
                    expected_data.push_back(b);
                end
                mips_isa_pkg::op_beq: if (a == b) next_pc = pc + 32'd4 + {simm[29:0], 2'b00};
                mips_isa_pkg::op_bne: if (a != b) next_pc = pc + 32'd4 + {simm[29:0], 2'b00};
                mips_isa_pkg::op_j: next_pc = {next_pc[31:28], ins.j.target, 2'b00};
                default: ;
            endcase
            regs[0] = '0; // register 0 is hardwired
            pc = next_pc;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (data_req.write === 1'b1) begin
            dmem[data_req.addr[9:2]] <= data_req.wdata;
        end
    end

    // a pending store is stable around the falling edge
    always @(negedge clk) begin
        if (data_req.write === 1'b1) begin
            if (expected_addr.size() == 0) begin
                errors++;
                $display("store to address %h at %0t was not expected by the reference model",
                         data_req.addr, $time);
            end else begin
                want_addr = expected_addr.pop_front();
                want_data = expected_data.pop_front();
                if (data_req.addr !== want_addr) begin
                    errors++;
                    $display("MISMATCH time %0t data_req.addr expected %h actual %h",
                             $time, want_addr, data_req.addr);
                end
                if (data_req.wdata !== want_data) begin
                    errors++;
                    $display("MISMATCH time %0t data_req.wdata expected %h actual %h",
                             $time, want_data, data_req.wdata);
                end
            end
        end
    end

    initial begin
        arst_n = 1'b0;
        program_ready = 1'b0;
        seed = 46022;
        errors = 0;
        prog_len = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = (i * 4) * 32'h9e37_79b9 + 32'h1357_9bdf;
        end
        build_program();
        run_model();
        program_ready = 1'b1;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        while (expected_addr.size() != 0 || iaddr != halt_pc) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk); // room for a stray store behind the final jump
        $display("errors: %0d store mismatches, %0d assertion failures",
                 errors, dut0.checks0.failures);
        if (errors == 0 && dut0.checks0.failures == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        wait (program_ready);
        #((prog_len * 8 + 16) * 10);
        $display("timeout: the core did not reach the final jump with every store seen");
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== core.f ====
mips_isa_pkg.sv
pipeline_pkg.sv
stage_fetch.sv
stage_decode.sv
stage_execute.sv
stage_memory.sv
main_forwarder.sv
pipeline_flow_controller.sv
core.sv
core_assert.sv
core_tb.sv
